// ==== rtl/lsuPkg.sv ====
package lsuPkg;

    // ========================================
    // Widths
    // ========================================
    localparam int xlen = 32;
    localparam int laneCount = xlen / 8;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [2:0] funct3_t;
    typedef logic [laneCount-1:0] byteEn_t;
    typedef logic [xlen-1:0] cause_t;

    // ========================================
    // Access size codes
    // ========================================
    // Same encoding as the funct3 field of loads and stores
    localparam funct3_t funct3Byte = 3'd0;
    localparam funct3_t funct3Half = 3'd1;
    localparam funct3_t funct3Word = 3'd2;
    localparam funct3_t funct3ByteU = 3'd4;
    localparam funct3_t funct3HalfU = 3'd5;

    // ========================================
    // Exception causes
    // ========================================
    localparam cause_t causeLoadMisaligned = 32'd4;
    localparam cause_t causeStoreMisaligned = 32'd6;

    // ========================================
    // Memory word views
    // ========================================
    // Byte 0 and halfword 0 sit in the low bits
    typedef union packed {
        word_t word;
        logic [laneCount-1:0][7:0] bytes;
        logic [laneCount/2-1:0][15:0] halves;
    } memWord_t;

endpackage

// ==== rtl/addrGen.sv ====
module addrGen (
    input logic clk,
    input logic reset,
    input logic reqValid,
    input logic reqStore,
    input lsuPkg::funct3_t reqFunct3,
    input lsuPkg::word_t reqBase,
    input lsuPkg::word_t reqOffset,
    input lsuPkg::word_t reqData,
    input lsuPkg::regAddr_t reqRd,
    output logic m1Valid,
    output logic m1Store,
    output lsuPkg::funct3_t m1Funct3,
    output lsuPkg::word_t m1Addr,
    output lsuPkg::word_t m1Data,
    output lsuPkg::regAddr_t m1Rd,
    output logic m1Exception,
    output lsuPkg::cause_t m1Cause
);
    import lsuPkg::*;

    logic exValid;
    logic exStore;
    funct3_t exFunct3;
    word_t exBase;
    word_t exOffset;
    word_t exData;
    regAddr_t exRd;
    word_t exAddr;
    logic misaligned;
    logic exException;
    cause_t exCause;

    // ========================================
    // Execute register
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exValid <= 1'b0;
            exStore <= 1'b0;
        end else begin
            exValid <= reqValid;
            exStore <= reqStore;
        end
    end

    always_ff @(posedge clk) begin
        exFunct3 <= reqFunct3;
        exBase <= reqBase;
        exOffset <= reqOffset;
        exData <= reqData;
        exRd <= reqRd;
    end

    // Address add, the only ALU operation kept
    assign exAddr = exBase + exOffset;

    // Words need 4-byte alignment, halfwords 2-byte
    assign misaligned = ((exFunct3 == funct3Word) && (exAddr[1:0] != 2'b00)) ||
                        (((exFunct3 == funct3Half) || (exFunct3 == funct3HalfU)) && exAddr[0]);

    assign exException = exValid && misaligned;
    assign exCause = !exException ? '0 :
                     (exStore ? causeStoreMisaligned : causeLoadMisaligned);

    // ========================================
    // Execute to memory stage one
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m1Valid <= 1'b0;
            m1Store <= 1'b0;
            m1Exception <= 1'b0;
        end else begin
            m1Valid <= exValid;
            m1Store <= exStore;
            m1Exception <= exException;
        end
    end

    always_ff @(posedge clk) begin
        m1Funct3 <= exFunct3;
        m1Addr <= exAddr;
        m1Data <= exData;
        m1Rd <= exRd;
        m1Cause <= exCause;
    end

endmodule

// ==== rtl/storeAlign.sv ====
module storeAlign (
    input logic m1Valid,
    input logic m1Store,
    input logic m1Exception,
    input lsuPkg::funct3_t m1Funct3,
    input lsuPkg::word_t m1Addr,
    input lsuPkg::word_t m1Data,
    output lsuPkg::byteEn_t wrEn,
    output lsuPkg::word_t wrData
);
    import lsuPkg::*;

    memWord_t aligned;
    byteEn_t laneEn;
    logic [1:0] offset;
    logic doWrite;

    assign offset = m1Addr[1:0];

    // Move the low byte or halfword into its lane
    always_comb begin
        aligned.word = '0;
        laneEn = '0;
        case (m1Funct3)
            funct3Byte: begin
                aligned.bytes[offset] = m1Data[7:0];
                laneEn = byteEn_t'(1) << offset;
            end
            funct3Half: begin
                aligned.halves[offset[1]] = m1Data[15:0];
                laneEn = offset[1] ? 4'b1100 : 4'b0011;
            end
            funct3Word: begin
                aligned.word = m1Data;
                laneEn = '1;
            end
            // Other codes store nothing
            default: begin
                aligned.word = m1Data;
            end
        endcase
    end

    // Trapped or non-store entries never touch the RAM
    assign doWrite = m1Valid && m1Store && !m1Exception;
    assign wrEn = doWrite ? laneEn : '0;
    assign wrData = aligned.word;

endmodule

// ==== rtl/dataRam.sv ====
module dataRam #(
    parameter int ramAddrBits = 8
) (
    input logic clk,
    input lsuPkg::word_t m1Addr,
    input lsuPkg::byteEn_t wrEn,
    input lsuPkg::word_t wrData,
    output lsuPkg::word_t rdData
);
    import lsuPkg::*;

    localparam int depth = 1 << ramAddrBits;

    word_t mem [0:depth-1];
    logic [ramAddrBits-1:0] wordIndex;

    // Byte offset bits dropped, upper bits ignored
    assign wordIndex = m1Addr[ramAddrBits+1:2];

    // ========================================
    // Byte-lane write, read of the old word
    // ========================================
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < laneCount; lane++) begin
            if (wrEn[lane]) begin
                mem[wordIndex][8*lane +: 8] <= wrData[8*lane +: 8];
            end
        end
        rdData <= mem[wordIndex];
    end

endmodule

// ==== rtl/loadExtract.sv ====
module loadExtract (
    input logic clk,
    input logic reset,
    input logic m1Valid,
    input logic m1Store,
    input lsuPkg::funct3_t m1Funct3,
    input lsuPkg::word_t m1Addr,
    input lsuPkg::regAddr_t m1Rd,
    input logic m1Exception,
    input lsuPkg::cause_t m1Cause,
    input lsuPkg::word_t rdData,
    output logic respValid,
    output logic respStore,
    output lsuPkg::regAddr_t respRd,
    output lsuPkg::word_t respData,
    output logic respException,
    output lsuPkg::cause_t respCause,
    output lsuPkg::word_t respTval
);
    import lsuPkg::*;

    logic m2Valid;
    logic m2Store;
    logic m2Exception;
    funct3_t m2Funct3;
    word_t m2Addr;
    regAddr_t m2Rd;
    cause_t m2Cause;
    memWord_t rdWord;
    logic [7:0] byteSel;
    logic [15:0] halfSel;
    word_t loadValue;

    // ========================================
    // Memory stage two register
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m2Valid <= 1'b0;
            m2Store <= 1'b0;
            m2Exception <= 1'b0;
        end else begin
            m2Valid <= m1Valid;
            m2Store <= m1Store;
            m2Exception <= m1Exception;
        end
    end

    always_ff @(posedge clk) begin
        m2Funct3 <= m1Funct3;
        m2Addr <= m1Addr;
        m2Rd <= m1Rd;
        m2Cause <= m1Cause;
    end

    // RAM word arrives in this cycle
    assign rdWord = rdData;
    assign byteSel = rdWord.bytes[m2Addr[1:0]];
    assign halfSel = rdWord.halves[m2Addr[1]];

    always_comb begin
        case (m2Funct3)
            funct3Byte: loadValue = {{(xlen-8){byteSel[7]}}, byteSel};
            funct3ByteU: loadValue = {{(xlen-8){1'b0}}, byteSel};
            funct3Half: loadValue = {{(xlen-16){halfSel[15]}}, halfSel};
            funct3HalfU: loadValue = {{(xlen-16){1'b0}}, halfSel};
            // Word and unsupported codes pass the full word
            default: loadValue = rdWord.word;
        endcase
    end

    // ========================================
    // Writeback register
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            respValid <= 1'b0;
            respStore <= 1'b0;
            respException <= 1'b0;
        end else begin
            respValid <= m2Valid;
            respStore <= m2Store;
            respException <= m2Exception;
        end
    end

    always_ff @(posedge clk) begin
        respRd <= m2Rd;
        respCause <= m2Cause;
        respTval <= m2Exception ? m2Addr : '0;
        respData <= (m2Store || m2Exception) ? '0 : loadValue;
    end

endmodule

// ==== rtl/lsuTop.sv ====
module lsuTop #(
    parameter int ramAddrBits = 8
) (
    input logic clk,
    input logic reset,
    input logic reqValid,
    input logic reqStore,
    input lsuPkg::funct3_t reqFunct3,
    input lsuPkg::word_t reqBase,
    input lsuPkg::word_t reqOffset,
    input lsuPkg::word_t reqData,
    input lsuPkg::regAddr_t reqRd,
    output logic respValid,
    output logic respStore,
    output lsuPkg::regAddr_t respRd,
    output lsuPkg::word_t respData,
    output logic respException,
    output lsuPkg::cause_t respCause,
    output lsuPkg::word_t respTval
);
    import lsuPkg::*;

    logic m1Valid;
    logic m1Store;
    funct3_t m1Funct3;
    word_t m1Addr;
    word_t m1Data;
    regAddr_t m1Rd;
    logic m1Exception;
    cause_t m1Cause;
    byteEn_t wrEn;
    word_t wrData;
    word_t rdData;

    // ========================================
    // Execute
    // ========================================
    addrGen exStage (
        .clk(clk), .reset(reset),
        .reqValid(reqValid), .reqStore(reqStore), .reqFunct3(reqFunct3),
        .reqBase(reqBase), .reqOffset(reqOffset), .reqData(reqData), .reqRd(reqRd),
        .m1Valid(m1Valid), .m1Store(m1Store), .m1Funct3(m1Funct3),
        .m1Addr(m1Addr), .m1Data(m1Data), .m1Rd(m1Rd),
        .m1Exception(m1Exception), .m1Cause(m1Cause)
    );

    // ========================================
    // Memory stage one
    // ========================================
    storeAlign storeStage (
        .m1Valid(m1Valid), .m1Store(m1Store), .m1Exception(m1Exception),
        .m1Funct3(m1Funct3), .m1Addr(m1Addr), .m1Data(m1Data),
        .wrEn(wrEn), .wrData(wrData)
    );

    dataRam #(.ramAddrBits(ramAddrBits)) ram (
        .clk(clk), .m1Addr(m1Addr),
        .wrEn(wrEn), .wrData(wrData),
        .rdData(rdData)
    );

    // ========================================
    // Memory stage two and writeback
    // ========================================
    loadExtract loadStage (
        .clk(clk), .reset(reset),
        .m1Valid(m1Valid), .m1Store(m1Store), .m1Funct3(m1Funct3),
        .m1Addr(m1Addr), .m1Rd(m1Rd),
        .m1Exception(m1Exception), .m1Cause(m1Cause),
        .rdData(rdData),
        .respValid(respValid), .respStore(respStore), .respRd(respRd),
        .respData(respData), .respException(respException),
        .respCause(respCause), .respTval(respTval)
    );

endmodule

// ==== tb/lsu_properties.sv ====
module lsuProperties (
    input logic clk, reset, reqValid, respValid, respException, m1Exception,
    input lsuPkg::cause_t respCause,
    input lsuPkg::byteEn_t wrEn
);
    timeunit 1ns;
    timeprecision 100ps;

    // Count of failed assertions
    int failCount = 0;

    // ========================================
    // Response and write-enable rules
    // ========================================
    resetQuiet: assert property (@(posedge clk) reset |-> !respValid)
        else begin
            failCount++;
            $error("respValid high while reset is asserted");
        end

    causeKnown: assert property (@(posedge clk) disable iff (reset)
        respException |-> (respCause == 32'd4 || respCause == 32'd6))
        else begin
            failCount++;
            $error("exception reported with a cause other than 4 or 6");
        end

    noTrapWrite: assert property (@(posedge clk) disable iff (reset)
        m1Exception |-> (wrEn == '0))
        else begin
            failCount++;
            $error("RAM byte enables active for a trapped access");
        end

    // Sampled values trail the writeback register by one edge, so four here
    fixedLatency: assert property (@(posedge clk) disable iff (reset)
        respValid == $past(reqValid, 4))
        else begin
            failCount++;
            $error("respValid does not follow reqValid by three cycles");
        end

endmodule

bind lsuTop lsuProperties props0 (
    .clk(clk), .reset(reset), .reqValid(reqValid), .respValid(respValid),
    .respException(respException), .m1Exception(m1Exception),
    .respCause(respCause), .wrEn(wrEn)
);

// ==== tb/lsuChecker.sv ====
module lsuChecker (
    input logic clk, reset, reqValid, reqStore, expException, endOfTest,
    input lsuPkg::regAddr_t reqRd,
    input lsuPkg::word_t reqBase, reqOffset, expData,
    input lsuPkg::cause_t expCause,
    input logic respValid, respStore, respException,
    input lsuPkg::regAddr_t respRd,
    input lsuPkg::word_t respData, respTval,
    input lsuPkg::cause_t respCause,
    output int testCount,
    output int errorCount
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsuPkg::*;

    // Expected values of requests in flight, oldest at head
    logic qStore [0:63];
    regAddr_t qRd [0:63];
    word_t qData [0:63];
    logic qExc [0:63];
    cause_t qCause [0:63];
    word_t qTval [0:63];
    int qStamp [0:63];
    int head = 0;
    int tail = 0;
    int edges = 0;
    int tests = 0;
    int errors = 0;
    bit endSeen = 1'b0;

    assign testCount = tests;
    assign errorCount = errors;

    task automatic checkField(input string name, input word_t got, input word_t exp,
                              inout bit ok);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            ok = 1'b0;
        end
    endtask

    // ========================================
    // Compare responses in order
    // ========================================
    always @(posedge clk) begin
        bit ok;
        if (!reset && respValid) begin
            if (head == tail) begin
                $display("response for rd %0d at %0t has no matching request", respRd, $time);
                errors++;
            end else begin
                ok = 1'b1;
                tests++;
                // Writeback loads three edges after the request and is seen one edge later
                if (edges - qStamp[head] != 4) begin
                    $display("rd %0d answered %0d cycles after its request instead of 3",
                             respRd, edges - qStamp[head] - 1);
                    errors++;
                    ok = 1'b0;
                end
                checkField("respStore", word_t'(respStore), word_t'(qStore[head]), ok);
                checkField("respRd", word_t'(respRd), word_t'(qRd[head]), ok);
                checkField("respData", respData, qData[head], ok);
                checkField("respException", word_t'(respException), word_t'(qExc[head]), ok);
                if (qExc[head]) begin
                    checkField("respCause", respCause, qCause[head], ok);
                end
                checkField("respTval", respTval, qTval[head], ok);
                $display("test %0d rd %0d %s", tests, respRd, ok ? "passed" : "failed");
                head++;
            end
        end
        if (!reset && reqValid) begin
            qStore[tail] = reqStore;
            qRd[tail] = reqRd;
            qData[tail] = expData;
            qExc[tail] = expException;
            qCause[tail] = expCause;
            // Trap value is the effective address
            qTval[tail] = expException ? reqBase + reqOffset : '0;
            qStamp[tail] = edges;
            tail++;
        end
        if (endOfTest && !endSeen) begin
            endSeen = 1'b1;
            if (tail != head) begin
                $display("%0d request(s) never received a response", tail - head);
                errors += tail - head;
            end
        end
        edges++;
    end

endmodule

// ==== tb/lsuTb.sv ====
module lsuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsuPkg::*;

    localparam int resetCycles = 16;
    localparam int latency = 3;
    localparam int timeoutMargin = 20;
    localparam int maxRows = 32;
    localparam logic opStore = 1'b1;
    localparam logic opLoad = 1'b0;
    localparam cause_t noCause = '0;
    localparam cause_t loadTrap = 32'd4;
    localparam cause_t storeTrap = 32'd6;

    logic clk = 1'b0;
    logic reset, reqValid, reqStore, expException, endOfTest;
    funct3_t reqFunct3;
    word_t reqBase, reqOffset, reqData, expData;
    regAddr_t reqRd;
    cause_t expCause;
    logic respValid, respStore, respException;
    regAddr_t respRd;
    word_t respData, respTval;
    cause_t respCause;
    int testCount, errorCount;

    // ========================================
    // Stimulus table
    // ========================================
    logic rowStore [maxRows];
    funct3_t rowFunct3 [maxRows];
    word_t rowBase [maxRows];
    word_t rowOffset [maxRows];
    word_t rowData [maxRows];
    word_t rowExpData [maxRows];
    logic rowExpExc [maxRows];
    cause_t rowExpCause [maxRows];
    int rowCount = 0;
    int seed = 51550;
    int cycleCount = 0;
    int timeoutLimit = 0;

    always #2 clk = ~clk;

    lsuTop #(.ramAddrBits(8)) dut0 (
        .clk(clk), .reset(reset), .reqValid(reqValid), .reqStore(reqStore),
        .reqFunct3(reqFunct3), .reqBase(reqBase), .reqOffset(reqOffset),
        .reqData(reqData), .reqRd(reqRd), .respValid(respValid), .respStore(respStore),
        .respRd(respRd), .respData(respData), .respException(respException),
        .respCause(respCause), .respTval(respTval)
    );

    lsuChecker check0 (.*);

    task automatic addRow(input logic store, input funct3_t f3, input word_t base,
                          input word_t offset, input word_t data, input word_t expected,
                          input logic exc, input cause_t cause);
        rowStore[rowCount] = store;
        rowFunct3[rowCount] = f3;
        rowBase[rowCount] = base;
        rowOffset[rowCount] = offset;
        rowData[rowCount] = data;
        rowExpData[rowCount] = expected;
        rowExpExc[rowCount] = exc;
        rowExpCause[rowCount] = cause;
        rowCount++;
    endtask

    // Random base, offset picked so the sum lands on the wanted address
    task automatic addRandomRow(input logic store, input funct3_t f3, input word_t addr,
                                input word_t data, input word_t expected, input logic exc,
                                input cause_t cause);
        word_t base;
        base = $random(seed);
        addRow(store, f3, base, addr - base, data, expected, exc, cause);
    endtask

    task automatic buildTable();
        // Word round trip, load on the very next cycle
        addRow(opStore, funct3Word, 32'h40, 32'h0, 32'h12345678, 32'h0, 1'b0, noCause);
        addRandomRow(opLoad, funct3Word, 32'h40, 32'h0, 32'h12345678, 1'b0, noCause);
        // Byte lanes of the word at 0x48
        addRow(opStore, funct3Word, 32'h40, 32'h8, 32'h11223344, 32'h0, 1'b0, noCause);
        addRow(opStore, funct3Byte, 32'h40, 32'h8, 32'hAAAAAA80, 32'h0, 1'b0, noCause);
        addRow(opStore, funct3Byte, 32'h40, 32'h9, 32'h000000F1, 32'h0, 1'b0, noCause);
        addRandomRow(opStore, funct3Byte, 32'h4B, 32'hFFFFFF9C, 32'h0, 1'b0, noCause);
        // Lane 2 still holds its old byte
        addRow(opLoad, funct3Word, 32'h48, 32'h0, 32'h0, 32'h9C22F180, 1'b0, noCause);
        addRow(opStore, funct3Byte, 32'h44, 32'h6, 32'h123456C5, 32'h0, 1'b0, noCause);
        addRow(opLoad, funct3Byte, 32'h48, 32'h0, 32'h0, 32'hFFFFFF80, 1'b0, noCause);
        addRow(opLoad, funct3ByteU, 32'h48, 32'h0, 32'h0, 32'h00000080, 1'b0, noCause);
        addRow(opLoad, funct3Byte, 32'h48, 32'h1, 32'h0, 32'hFFFFFFF1, 1'b0, noCause);
        addRow(opLoad, funct3Byte, 32'h48, 32'h2, 32'h0, 32'hFFFFFFC5, 1'b0, noCause);
        addRandomRow(opLoad, funct3ByteU, 32'h4B, 32'h0, 32'h0000009C, 1'b0, noCause);
        addRow(opLoad, funct3Word, 32'h48, 32'h0, 32'h0, 32'h9CC5F180, 1'b0, noCause);
        // Halfwords of the word at 0x50
        addRow(opStore, funct3Word, 32'h50, 32'h0, 32'hDEADBEEF, 32'h0, 1'b0, noCause);
        addRow(opStore, funct3Half, 32'h50, 32'h0, 32'h12348001, 32'h0, 1'b0, noCause);
        addRow(opLoad, funct3Half, 32'h50, 32'h0, 32'h0, 32'hFFFF8001, 1'b0, noCause);
        addRow(opLoad, funct3HalfU, 32'h50, 32'h2, 32'h0, 32'h0000DEAD, 1'b0, noCause);
        addRandomRow(opStore, funct3Half, 32'h52, 32'h00007FFE, 32'h0, 1'b0, noCause);
        addRow(opLoad, funct3Half, 32'h4E, 32'h4, 32'h0, 32'h00007FFE, 1'b0, noCause);
        addRow(opLoad, funct3Word, 32'h50, 32'h0, 32'h0, 32'h7FFE8001, 1'b0, noCause);
        // Misaligned accesses trap and leave the word at 0x48 as it was
        addRow(opStore, funct3Word, 32'h40, 32'hA, 32'hFFFFFFFF, 32'h0, 1'b1, storeTrap);
        addRandomRow(opStore, funct3Half, 32'h49, 32'h0000FFFF, 32'h0, 1'b1, storeTrap);
        addRow(opLoad, funct3Word, 32'h40, 32'hB, 32'h0, 32'h0, 1'b1, loadTrap);
        addRow(opLoad, funct3HalfU, 32'h4, 32'h49, 32'h0, 32'h0, 1'b1, loadTrap);
        addRow(opLoad, funct3Word, 32'h48, 32'h0, 32'h0, 32'h9CC5F180, 1'b0, noCause);
    endtask

    task automatic driveRow(input int i);
        reqValid = 1'b1;
        reqStore = rowStore[i];
        reqFunct3 = rowFunct3[i];
        reqBase = rowBase[i];
        reqOffset = rowOffset[i];
        reqData = rowData[i];
        reqRd = regAddr_t'(i % 31 + 1);
        expData = rowExpData[i];
        expException = rowExpExc[i];
        expCause = rowExpCause[i];
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        reset = 1'b1;
        reqValid = 1'b0;
        reqStore = 1'b0;
        reqFunct3 = funct3Word;
        reqBase = '0;
        reqOffset = '0;
        reqData = '0;
        reqRd = '0;
        expData = '0;
        expException = 1'b0;
        expCause = '0;
        endOfTest = 1'b0;
        buildTable();
        // Limit sized from reset, table length and pipeline depth
        timeoutLimit = resetCycles + rowCount + latency + timeoutMargin;
        repeat (resetCycles) @(posedge clk);
        #0.5 reset = 1'b0;
        // One request per cycle, no gaps
        for (int i = 0; i < rowCount; i++) begin
            @(posedge clk);
            #0.5;
            driveRow(i);
        end
        @(posedge clk);
        #0.5 reqValid = 1'b0;
        while (testCount < rowCount && cycleCount < timeoutLimit) @(negedge clk);
        if (testCount < rowCount) begin
            $display("timeout after %0d cycles with %0d of %0d responses checked",
                     cycleCount, testCount, rowCount);
        end
        endOfTest = 1'b1;
        @(posedge clk);
        @(negedge clk);
        $display("%0d of %0d tests checked, %0d errors, %0d assertion failures",
                 testCount, rowCount, errorCount, dut0.props0.failCount);
        if (errorCount == 0 && dut0.props0.failCount == 0 && testCount == rowCount) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Cycles since the start, read by the response wait
    always @(posedge clk) begin
        cycleCount++;
    end

endmodule

// ==== flist.f ====
rtl/lsuPkg.sv
rtl/addrGen.sv
rtl/storeAlign.sv
rtl/dataRam.sv
rtl/loadExtract.sv
rtl/lsuTop.sv
tb/lsu_properties.sv
tb/lsuChecker.sv
tb/lsuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= lsuTb
FLIST ?= flist.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: compile
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG) || \
		! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
